/* sim.f */
+incdir+verilog
verilog/eth_stream_pkg.sv
verilog/eth_fcs_pkg.sv
verilog/eth_crc_8.sv
verilog/axis_eth_fcs.sv
verilog/eth_fcs_check.sv
verilog/eth_fcs_regs.sv
verilog/eth_fcs_top.sv
test/eth_fcs_chk.sv
test/eth_fcs_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the FCS testbench with Verilator, run it, then scan the log.
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module eth_fcs_tb -f sim.f \
    && ./obj_dir/Veth_fcs_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "CHECKS FAILED" sim.log 2>/dev/null && { echo "simulation FAILED"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null || { echo "simulation FAILED"; exit 1; }
echo "simulation passed"

/* test/eth_fcs_tb.sv */
/*
 * Random-frame testbench for the Ethernet FCS subsystem.
 * Drives tx and rx byte streams, predicts every FCS and verdict with a
 * bitwise CRC model, and reads counters and LAST_FCS over the register
 * bus. A negedge monitor compares both result ports on every cycle.
 */

`timescale 1ns/100ps

`include "eth_fcs_params.svh"

module eth_fcs_tb;

    localparam int TIMEOUT = 200; // cycles allowed per wait.

    logic                   clk;
    logic                   rst;
    eth_stream_pkg::beat_t  tx_in;
    eth_stream_pkg::beat_t  rx_in;
    eth_fcs_pkg::fcs_res_t  tx_fcs;
    eth_fcs_pkg::chk_res_t  rx_res;
    eth_fcs_pkg::reg_wr_t   reg_wr;
    logic [`REG_ADDR_W-1:0] reg_addr;
    logic [31:0]            reg_rdata;

    logic [31:0]           rng;           // xorshift state.
    logic [7:0]            frame_data[$]; // bytes of the frame in flight.
    logic                  frame_user[$]; // user bit per byte.
    logic [31:0]           exp_fcs_q[$];  // predicted tx fcs, oldest first.
    eth_fcs_pkg::chk_res_t exp_res_q[$];  // predicted rx verdicts.
    logic [31:0]           held_fcs;      // fcs the generator should hold.
    eth_fcs_pkg::chk_res_t held_res;      // verdict the checker should hold.
    eth_fcs_pkg::fcs_res_t exp_f;
    eth_fcs_pkg::chk_res_t exp_r;
    logic                  prev_tx_last;  // tx last beat offered last cycle.
    logic                  prev_rx_fire;  // enabled rx last beat last cycle.
    logic                  en_model;      // check_en as last written.
    logic [31:0]           last_sent_fcs;
    int                    good_tally;
    int                    bad_tally;

    eth_fcs_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .tx_in     (tx_in),
        .rx_in     (rx_in),
        .tx_fcs    (tx_fcs),
        .rx_res    (rx_res),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_rdata (reg_rdata)
    );

    bind eth_fcs_top eth_fcs_chk i_chk (
        .clk    (clk),
        .rst    (rst),
        .rx_in  (rx_in),
        .tx_fcs (tx_fcs),
        .rx_res (rx_res)
    );

    always #5 clk = ~clk; // 10 ns period.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random numbers and crc model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        rng = xorshift32(rng);
        return lo + int'(rng % (hi - lo + 1));
    endfunction

    // crc register over the first n bytes, lsb first.
    function automatic logic [31:0] crc_model(input int n);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < n; i++) begin
            c = c ^ {24'h0, frame_data[i]};
            for (int k = 0; k < 8; k++) begin
                c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
            end
        end
        return c;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_fcs(input eth_fcs_pkg::fcs_res_t got,
                             input eth_fcs_pkg::fcs_res_t exp);
        if (got.valid !== exp.valid) begin
            fail_stop($sformatf("error at %0t: tx_fcs.valid got %b expected %b",
                                $time, got.valid, exp.valid));
        end else if (got.fcs !== exp.fcs) begin
            fail_stop($sformatf("error at %0t: tx_fcs.fcs got %h expected %h",
                                $time, got.fcs, exp.fcs));
        end
    endtask

    task automatic check_res(input eth_fcs_pkg::chk_res_t got,
                             input eth_fcs_pkg::chk_res_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("error at %0t: rx_res {valid,good,user_err} got %b expected %b",
                                $time, got, exp));
        end
    endtask

    task automatic check_reg(input logic [31:0] got, input logic [31:0] exp,
                             input string name);
        if (got !== exp) begin
            fail_stop($sformatf("error at %0t: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    // result monitor, both ports checked every cycle.
    always @(negedge clk) begin
        if (!rst) begin
            if (prev_tx_last) begin
                held_fcs = exp_fcs_q.pop_front(); // one push per tx frame.
            end
            exp_f.valid = prev_tx_last;
            exp_f.fcs   = held_fcs;
            check_fcs(tx_fcs, exp_f);
            if (prev_rx_fire) begin
                held_res = exp_res_q.pop_front();
                if (held_res.good) begin
                    good_tally++;
                end else begin
                    bad_tally++;
                end
            end
            exp_r       = held_res;
            exp_r.valid = prev_rx_fire;
            check_res(rx_res, exp_r);
            prev_tx_last = tx_in.valid && tx_in.last;
            prev_rx_fire = rx_in.valid && rx_in.last && en_model;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic idle_streams(input int n);
        repeat (n) begin
            @(posedge clk);
            tx_in <= '0;
            rx_in <= '0;
        end
    endtask

    task automatic drive_beats(input logic is_rx);
        eth_stream_pkg::beat_t b;
        for (int i = 0; i < frame_data.size(); i++) begin
            b.valid = 1'b1;
            b.data  = frame_data[i];
            b.last  = (i == frame_data.size() - 1);
            b.user  = frame_user[i];
            @(posedge clk);
            if (is_rx) begin
                rx_in <= b;
            end else begin
                tx_in <= b;
            end
        end
    endtask

    task automatic send_tx_frame();
        int len;
        int gap;
        len = rand_range(5, 40);
        frame_data.delete();
        frame_user.delete();
        for (int i = 0; i < len; i++) begin
            frame_data.push_back(8'(rand_range(0, 255)));
            frame_user.push_back(rand_range(0, 7) == 0); // ignored on tx.
        end
        last_sent_fcs = ~crc_model(len);
        exp_fcs_q.push_back(last_sent_fcs);
        drive_beats(1'b0);
        gap = rand_range(0, 2); // zero gives back to back.
        idle_streams(gap);
    endtask

    // kind 0 corrupts one fcs byte, kind 1 sets a user bit.
    task automatic send_rx_frame(input int kind);
        int                    len;
        int                    pos;
        logic [31:0]           fcs;
        eth_fcs_pkg::chk_res_t exp;
        len = rand_range(5, 40);
        frame_data.delete();
        frame_user.delete();
        for (int i = 0; i < len; i++) begin
            frame_data.push_back(8'(rand_range(0, 255)));
            frame_user.push_back(1'b0);
        end
        fcs = ~crc_model(len);
        for (int i = 0; i < 4; i++) begin
            frame_data.push_back(fcs[8*i +: 8]); // low byte first on the wire.
            frame_user.push_back(1'b0);
        end
        if (kind == 0) begin
            pos = len + rand_range(0, 3);
            frame_data[pos] = frame_data[pos] ^ 8'(rand_range(1, 255));
        end else if (kind == 1) begin
            pos = rand_range(0, len + 3);
            frame_user[pos] = 1'b1;
        end
        exp.valid    = 1'b1;
        exp.user_err = (kind == 1);
        exp.good     = (kind != 0) && !exp.user_err; // fcs intact, no user bit.
        if (en_model) begin
            exp_res_q.push_back(exp);
        end
        drive_beats(1'b1);
        idle_streams(rand_range(0, 2));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register access and waits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic write_reg(input logic [`REG_ADDR_W-1:0] addr, input logic [31:0] data);
        eth_fcs_pkg::reg_wr_t w;
        w.wr    = 1'b1;
        w.addr  = addr;
        w.wdata = data;
        @(posedge clk);
        reg_wr <= w;
        @(posedge clk); // write lands here.
        reg_wr <= '0;
        if (addr == `REG_CTRL) begin
            en_model = data[0];
            if (data[1]) begin
                good_tally = 0;
                bad_tally  = 0;
            end
        end
    endtask

    task automatic expect_reg(input logic [`REG_ADDR_W-1:0] addr, input logic [31:0] exp,
                              input string name);
        @(posedge clk);
        reg_addr <= addr;
        @(negedge clk); // read mux settled.
        check_reg(reg_rdata, exp, name);
    endtask

    task automatic wait_results();
        int cnt;
        cnt = 0;
        while (exp_fcs_q.size() != 0 || exp_res_q.size() != 0) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) begin
                fail_stop("timeout: a tx_fcs or rx_res strobe never arrived");
            end
        end
        repeat (2) @(posedge clk); // counters update after the strobe.
    endtask

    task automatic quiet_window();
        for (int i = 0; i < TIMEOUT; i++) begin
            @(negedge clk);
            if (rx_res.valid) begin
                fail_stop("rx_res.valid rose while check_en was cleared");
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        tx_in = '0;
        rx_in = '0;
        reg_wr = '0;
        reg_addr = `REG_CTRL;
        rng = 32'heb6c;
        held_fcs = '0;
        held_res = '0;
        prev_tx_last = 1'b0;
        prev_rx_fire = 1'b0;
        en_model = 1'b1;
        last_sent_fcs = '0;
        good_tally = 0;
        bad_tally = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        idle_streams(3);
        expect_reg(`REG_CTRL, 32'h1, "reg_rdata ctrl");
        expect_reg(`REG_LAST_FCS, 32'h0, "reg_rdata last_fcs");
        for (int n = 0; n < 24; n++) begin
            send_tx_frame();
        end
        idle_streams(2);
        wait_results();
        for (int n = 0; n < 30; n++) begin
            send_rx_frame(rand_range(0, 3));
        end
        idle_streams(2);
        wait_results();
        expect_reg(`REG_GOOD_CNT, 32'(good_tally), "reg_rdata good_cnt");
        expect_reg(`REG_BAD_CNT, 32'(bad_tally), "reg_rdata bad_cnt");
        expect_reg(`REG_LAST_FCS, last_sent_fcs, "reg_rdata last_fcs");
        write_reg(`REG_CTRL, 32'h3); // clear, keep checking on.
        expect_reg(`REG_GOOD_CNT, 32'h0, "reg_rdata good_cnt");
        expect_reg(`REG_BAD_CNT, 32'h0, "reg_rdata bad_cnt");
        write_reg(`REG_CTRL, 32'h0);
        expect_reg(`REG_CTRL, 32'h0, "reg_rdata ctrl");
        for (int n = 0; n < 5; n++) begin
            send_rx_frame(rand_range(0, 3));
        end
        idle_streams(1);
        quiet_window();
        expect_reg(`REG_GOOD_CNT, 32'h0, "reg_rdata good_cnt");
        expect_reg(`REG_BAD_CNT, 32'h0, "reg_rdata bad_cnt");
        write_reg(`REG_CTRL, 32'h1);
        for (int n = 0; n < 6; n++) begin
            send_rx_frame(n % 3);
        end
        idle_streams(2);
        wait_results();
        expect_reg(`REG_GOOD_CNT, 32'(good_tally), "reg_rdata good_cnt");
        expect_reg(`REG_BAD_CNT, 32'(bad_tally), "reg_rdata bad_cnt");
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* test/eth_fcs_chk.sv */
/*
 * Concurrent assertions on the result strobes of the FCS top level.
 * Bound into eth_fcs_top by the testbench.
 */

`timescale 1ns/100ps

module eth_fcs_chk (
    input logic                  clk,
    input logic                  rst,
    input eth_stream_pkg::beat_t rx_in,  // receive stream.
    input eth_fcs_pkg::fcs_res_t tx_fcs, // generator result.
    input eth_fcs_pkg::chk_res_t rx_res  // checker result.
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // strobe shape
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_tx_single: assert property (@(posedge clk) disable iff (rst)
        tx_fcs.valid |=> !tx_fcs.valid)
        else $error("tx_fcs.valid high on two cycles in a row");

    a_rx_single: assert property (@(posedge clk) disable iff (rst)
        rx_res.valid |=> !rx_res.valid)
        else $error("rx_res.valid high on two cycles in a row");

    // a verdict only follows an accepted last beat.
    a_rx_cause: assert property (@(posedge clk) disable iff (rst)
        rx_res.valid |-> $past(rx_in.valid && rx_in.last))
        else $error("rx_res.valid without an rx last beat one cycle before");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reset exit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> (!tx_fcs.valid && !rx_res.valid))
        else $error("a result strobe is high right after reset");

endmodule

/* verilog/eth_fcs_top.sv */
/*
 * Top level of the Ethernet FCS subsystem.
 * The transmit stream goes to the generator, the receive stream to the
 * checker. The register block counts checker results, latches each
 * generated FCS and drives the checker's enable.
 */

`timescale 1ns/100ps

`include "eth_fcs_params.svh"

module eth_fcs_top (
    input  logic                   clk,
    input  logic                   rst,
    input  eth_stream_pkg::beat_t  tx_in,     // transmit byte stream.
    input  eth_stream_pkg::beat_t  rx_in,     // receive stream with fcs.
    output eth_fcs_pkg::fcs_res_t  tx_fcs,    // generated fcs.
    output eth_fcs_pkg::chk_res_t  rx_res,    // check verdict.
    input  eth_fcs_pkg::reg_wr_t   reg_wr,    // register writes.
    input  logic [`REG_ADDR_W-1:0] reg_addr,  // register read address.
    output logic [31:0]            reg_rdata  // register read data.
);

    eth_fcs_pkg::cfg_t cfg; // register block to checker.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapaths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    axis_eth_fcs i_gen (
        .clk     (clk),
        .rst     (rst),
        .tx_in   (tx_in),
        .fcs_out (tx_fcs)
    );

    eth_fcs_check i_check (
        .clk   (clk),
        .rst   (rst),
        .rx_in (rx_in),
        .cfg   (cfg),
        .res   (rx_res)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    eth_fcs_regs i_regs (
        .clk       (clk),
        .rst       (rst),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_rdata (reg_rdata),
        .fcs_in    (tx_fcs),  // latched into LAST_FCS.
        .chk_in    (rx_res),  // counted good or bad.
        .cfg       (cfg)
    );

endmodule

/* verilog/eth_fcs_regs.sv */
/*
 * Register block beside the FCS checker.
 * CTRL bit 0 is check_en, bit 1 is a self-clearing counter clear.
 * GOOD_CNT and BAD_CNT count checker results, LAST_FCS keeps the most
 * recent generated FCS. Writes land at the strobe edge and reads are
 * a combinational mux on reg_addr.
 */

`timescale 1ns/100ps

`include "eth_fcs_params.svh"

module eth_fcs_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  eth_fcs_pkg::reg_wr_t   reg_wr,    // write bundle.
    input  logic [`REG_ADDR_W-1:0] reg_addr,  // read address.
    output logic [31:0]            reg_rdata, // read data.
    input  eth_fcs_pkg::fcs_res_t  fcs_in,    // from the generator.
    input  eth_fcs_pkg::chk_res_t  chk_in,    // from the checker.
    output eth_fcs_pkg::cfg_t      cfg        // to the checker.
);

    logic                  ctrl_wr;   // write to CTRL this cycle.
    logic                  cnt_clr;   // counter clear strobe.
    logic [`FCS_CNT_W-1:0] good_cnt;  // frames judged good.
    logic [`FCS_CNT_W-1:0] bad_cnt;   // frames judged bad.
    logic [31:0]           last_fcs;  // latest tx fcs.

    assign ctrl_wr = reg_wr.wr && (reg_wr.addr == `REG_CTRL);
    assign cnt_clr = ctrl_wr && reg_wr.wdata[1]; // not stored.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control and counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.check_en <= 1'b1; // checking on out of reset.
            good_cnt     <= '0;
            bad_cnt      <= '0;
        end else begin
            if (ctrl_wr) begin
                cfg.check_en <= reg_wr.wdata[0];
            end
            if (cnt_clr) begin
                good_cnt <= '0; // clear wins over increment.
                bad_cnt  <= '0;
            end else if (chk_in.valid) begin
                if (chk_in.good) begin
                    good_cnt <= good_cnt + 1; // wraps.
                end else begin
                    bad_cnt <= bad_cnt + 1;
                end
            end
        end
    end

    // latest fcs, loaded on each generator strobe.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_fcs <= '0;
        end else if (fcs_in.valid) begin
            last_fcs <= fcs_in.fcs;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        reg_rdata = '0; // unused bits read zero.
        case (reg_addr)
            `REG_CTRL:     reg_rdata[0] = cfg.check_en;
            `REG_GOOD_CNT: reg_rdata[`FCS_CNT_W-1:0] = good_cnt;
            `REG_BAD_CNT:  reg_rdata[`FCS_CNT_W-1:0] = bad_cnt;
            `REG_LAST_FCS: reg_rdata = last_fcs;
            default:       reg_rdata = '0;
        endcase
    end

endmodule

/* verilog/eth_fcs_check.sv */
/*
 * Receive FCS checker for an 8-bit byte stream.
 * The last four bytes of each frame are its FCS, so the CRC register
 * lands on the fixed residue for a clean frame. A user bit on any beat
 * marks the frame bad. Results appear only while check_en is set.
 */

`timescale 1ns/100ps

`include "eth_fcs_params.svh"

module eth_fcs_check (
    input  logic                   clk,
    input  logic                   rst,
    input  eth_stream_pkg::beat_t  rx_in, // frame bytes plus fcs.
    input  eth_fcs_pkg::cfg_t      cfg,   // check enable.
    output eth_fcs_pkg::chk_res_t  res    // per-frame verdict.
);

    logic [31:0] crc_q;      // running crc including fcs bytes.
    logic [31:0] crc_next;   // crc after this beat.
    logic        user_err_q; // user bit seen earlier in the frame.
    logic        user_seen;  // sticky flag including this beat.
    logic        crc_ok;     // residue reached on this beat.

    eth_crc_8 i_crc (
        .data_in   (rx_in.data),
        .crc_state (crc_q),
        .crc_next  (crc_next)
    );

    assign user_seen = user_err_q | rx_in.user;
    assign crc_ok    = (crc_next == `ETH_CRC_RESIDUE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame state and verdict
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_q        <= `ETH_CRC_INIT;
            user_err_q   <= 1'b0;
            res.valid    <= 1'b0;
            res.good     <= 1'b0;
            res.user_err <= 1'b0;
        end else begin
            res.valid <= 1'b0; // single-cycle strobe.
            if (rx_in.valid) begin
                if (rx_in.last) begin
                    crc_q      <= `ETH_CRC_INIT; // reset even when disabled.
                    user_err_q <= 1'b0;
                    if (cfg.check_en) begin
                        res.valid    <= 1'b1;
                        res.good     <= crc_ok & ~user_seen;
                        res.user_err <= user_seen;
                    end
                end else begin
                    crc_q      <= crc_next;
                    user_err_q <= user_seen; // sticky until last.
                end
            end
        end
    end

endmodule

/* verilog/axis_eth_fcs.sv */
/*
 * Transmit FCS generator for an 8-bit byte stream.
 * Runs the CRC over every accepted byte up to and including the last
 * beat, then presents the complemented CRC with a one-cycle valid.
 * The stream is always accepted and the user bit plays no part.
 */

`timescale 1ns/100ps

`include "eth_fcs_params.svh"

module axis_eth_fcs (
    input  logic                   clk,
    input  logic                   rst,
    input  eth_stream_pkg::beat_t  tx_in,  // frame bytes.
    output eth_fcs_pkg::fcs_res_t  fcs_out // fcs of the finished frame.
);

    logic [31:0] crc_q;    // running crc of the current frame.
    logic [31:0] crc_next; // crc including this beat's byte.

    eth_crc_8 i_crc (
        .data_in   (tx_in.data),
        .crc_state (crc_q),
        .crc_next  (crc_next)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_q         <= `ETH_CRC_INIT;
            fcs_out.valid <= 1'b0;
            fcs_out.fcs   <= '0;
        end else begin
            fcs_out.valid <= 1'b0; // strobe lasts one cycle.
            if (tx_in.valid) begin
                if (tx_in.last) begin
                    crc_q         <= `ETH_CRC_INIT; // next frame starts clean.
                    fcs_out.fcs   <= ~crc_next;     // held until next frame ends.
                    fcs_out.valid <= 1'b1;
                end else begin
                    crc_q <= crc_next;
                end
            end
        end
    end

endmodule

/* verilog/eth_crc_8.sv */
/*
 * One-byte update of the reflected CRC-32 used for the Ethernet FCS.
 * Purely combinational. Feed the current register in, get the register
 * after one data byte out. Bits are taken lsb first as on the wire.
 */

`timescale 1ns/100ps

`include "eth_fcs_params.svh"

module eth_crc_8 (
    input  logic [7:0]  data_in,   // byte to absorb.
    input  logic [31:0] crc_state, // register before the byte.
    output logic [31:0] crc_next   // register after the byte.
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // eight serial steps, unrolled
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [31:0] crc; // working copy through the steps.
    logic        fb;  // feedback bit of the current step.

    always_comb begin
        crc = crc_state;
        fb  = 1'b0;
        for (int i = 0; i < 8; i++) begin
            fb = crc[0] ^ data_in[i]; // lsb out meets next data bit.
            if (fb) begin
                crc = (crc >> 1) ^ `ETH_CRC_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
        crc_next = crc;
    end

    // the register is kept uninverted here.
    // callers complement it for the transmitted fcs.

endmodule

/* verilog/eth_fcs_pkg.sv */
/*
 * Result, status, configuration and register-bus types of the FCS
 * subsystem. The generator drives fcs_res_t, the checker chk_res_t,
 * and the register block drives cfg_t and takes reg_wr_t writes.
 */

`include "eth_fcs_params.svh"

package eth_fcs_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath results
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic        valid; // one-cycle strobe after last beat.
        logic [31:0] fcs;   // complemented crc, held until next frame.
    } fcs_res_t;

    typedef struct packed {
        logic valid;    // one-cycle strobe after last beat.
        logic good;     // residue matched and no user error.
        logic user_err; // user bit seen somewhere in the frame.
    } chk_res_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic check_en; // checker produces results when set.
    } cfg_t;

    typedef struct packed {
        logic                   wr;    // write strobe.
        logic [`REG_ADDR_W-1:0] addr;  // target register.
        logic [31:0]            wdata; // write data.
    } reg_wr_t;

endpackage

/* verilog/eth_stream_pkg.sv */
/*
 * Byte-stream beat type shared by the transmit generator and the
 * receive checker. One beat is consumed in every cycle where valid is
 * high. There is no ready, so the sink always accepts.
 */

package eth_stream_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stream beat
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic       valid; // beat present this cycle.
        logic [7:0] data;  // one frame byte.
        logic       last;  // final byte of the frame.
        logic       user;  // error flagged by upstream.
    } beat_t;

    // eleven bits in total, packed msb first in the field order above.

endpackage

/* verilog/eth_fcs_params.svh */
/*
 * Shared constants for the Ethernet FCS subsystem.
 * CRC start value, polynomial, good-frame residue, counter width and
 * the register map. Include wherever one of these macros is needed.
 */

`ifndef ETH_FCS_PARAMS_SVH
`define ETH_FCS_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// crc constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define ETH_CRC_INIT    32'hFFFF_FFFF // register start value.
`define ETH_CRC_POLY    32'hEDB8_8320 // reflected crc-32 polynomial.
`define ETH_CRC_RESIDUE 32'hDEBB_20E3 // register after a good frame plus fcs.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FCS_CNT_W    16    // frame counter width.
`define REG_ADDR_W   2     // register address width.
`define REG_CTRL     2'd0  // check_en and counter clear.
`define REG_GOOD_CNT 2'd1  // good frames seen.
`define REG_BAD_CNT  2'd2  // bad frames seen.
`define REG_LAST_FCS 2'd3  // most recent generated fcs.

`endif
